/* exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// integer datapath width
`define XLEN 32

// register file address width, x0..x31
`define REG_AW 5

`endif

/* exec_pkg.sv */
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sub    = 4'b0001,
        alu_and    = 4'b0010,
        alu_or     = 4'b0011,
        alu_sltu   = 4'b0100,
        alu_slt    = 4'b0101,
        alu_xor    = 4'b0110,
        alu_sll    = 4'b0111,
        alu_srl    = 4'b1000,
        alu_sra    = 4'b1001,
        alu_pass_b = 4'b1010
    } alu_op_t;

    // writeback source
    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10,
        res_imm = 2'b11
    } result_src_t;

    // operand source chosen by forwarding
    typedef enum logic [2:0] {
        fwd_reg      = 3'd0,
        fwd_alu_m    = 3'd1,
        fwd_pc4_m    = 3'd2,
        fwd_imm_m    = 3'd3,
        fwd_result_w = 3'd4
    } fwd_sel_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        result_src_t result_src;
        alu_op_t     alu_control;
        logic        alu_src;
        logic        pc_src_a;
        logic        branch;
        logic        jump;
        logic        funct3_0;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   pc_plus4;
        logic [`XLEN-1:0]   imm_ext;
        logic [`XLEN-1:0]   rd1;
        logic [`XLEN-1:0]   rd2;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
    } ex_data_t;

    typedef struct packed {
        logic               reg_write;
        logic               mem_write;
        logic               mem_read;
        result_src_t        result_src;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   data_addr;
        logic [`XLEN-1:0]   write_data;
        logic [`XLEN-1:0]   pc_plus4;
        logic [`XLEN-1:0]   imm_ext;
        logic [`REG_AW-1:0] rd;
    } mem_stage_t;

    typedef struct packed {
        fwd_sel_t sel_a;
        fwd_sel_t sel_b;
    } fwd_ctrl_t;

endpackage

`default_nettype wire

/* alu.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module alu
    import exec_pkg::*;
(
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [`XLEN-1:0] imm_ext,
    input  alu_op_t          alu_control,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic [`XLEN-1:0] data_addr
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_control)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sltu: begin
                result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_slt: begin
                result = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            // lui
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

    // load/store address, independent of the op code
    assign data_addr = a + imm_ext;

endmodule

`default_nettype wire

/* forward_unit.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module forward_unit
    import exec_pkg::*;
(
    input  ex_data_t           ex_data,
    input  mem_stage_t         mem_stage,
    input  logic [`REG_AW-1:0] rd_w,
    input  logic               reg_write_w,
    output fwd_ctrl_t          fwd
);

    logic     m_writes;
    logic     w_writes;
    fwd_sel_t m_sel;

    // loads in memory are never forwarded, no stall logic here
    assign m_writes = mem_stage.reg_write && (mem_stage.rd != '0) &&
                      (mem_stage.result_src != res_mem);
    assign w_writes = reg_write_w && (rd_w != '0);

    always_comb begin
        case (mem_stage.result_src)
            res_pc4: begin
                m_sel = fwd_pc4_m;
            end
            res_imm: begin
                m_sel = fwd_imm_m;
            end
            default: begin
                m_sel = fwd_alu_m;
            end
        endcase
    end

    // memory stage first, then writeback, then the decoded value
    function automatic fwd_sel_t pick_src(
        input logic [`REG_AW-1:0] rs,
        input logic               m_ok,
        input logic [`REG_AW-1:0] m_rd,
        input fwd_sel_t           m_src,
        input logic               w_ok,
        input logic [`REG_AW-1:0] w_rd
    );
        fwd_sel_t sel;
        sel = fwd_reg;
        if (m_ok && (m_rd == rs)) begin
            sel = m_src;
        end else if (w_ok && (w_rd == rs)) begin
            sel = fwd_result_w;
        end
        return sel;
    endfunction

    always_comb begin
        fwd.sel_a = pick_src(ex_data.rs1, m_writes, mem_stage.rd, m_sel, w_writes, rd_w);
        fwd.sel_b = pick_src(ex_data.rs2, m_writes, mem_stage.rd, m_sel, w_writes, rd_w);
    end

endmodule

`default_nettype wire

/* operand_mux.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module operand_mux
    import exec_pkg::*;
(
    input  ex_ctrl_t         ex_ctrl,
    input  ex_data_t         ex_data,
    input  fwd_ctrl_t        fwd,
    input  mem_stage_t       mem_stage,
    input  logic [`XLEN-1:0] result_w,
    output logic [`XLEN-1:0] src_a,
    output logic [`XLEN-1:0] src_b,
    output logic [`XLEN-1:0] fwd_b
);

    logic [`XLEN-1:0] fwd_a;

    function automatic logic [`XLEN-1:0] fwd_value(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_val,
        input mem_stage_t       m,
        input logic [`XLEN-1:0] w_val
    );
        logic [`XLEN-1:0] val;
        case (sel)
            fwd_alu_m:    val = m.alu_result;
            fwd_pc4_m:    val = m.pc_plus4;
            fwd_imm_m:    val = m.imm_ext;
            fwd_result_w: val = w_val;
            default:      val = reg_val;
        endcase
        return val;
    endfunction

    assign fwd_a = fwd_value(fwd.sel_a, ex_data.rd1, mem_stage, result_w);
    assign fwd_b = fwd_value(fwd.sel_b, ex_data.rd2, mem_stage, result_w);

    // auipc and jal take the pc on side a
    assign src_a = ex_ctrl.pc_src_a ? ex_data.pc : fwd_a;
    assign src_b = ex_ctrl.alu_src ? ex_data.imm_ext : fwd_b;

endmodule

`default_nettype wire

/* branch_unit.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module branch_unit
    import exec_pkg::*;
(
    input  ex_ctrl_t         ex_ctrl,
    input  ex_data_t         ex_data,
    input  logic [`XLEN-1:0] alu_result,
    input  logic             zero,
    output logic             pc_src_e,
    output logic [`XLEN-1:0] pc_target_e
);

    logic cond;

    // funct3 bit 0 turns beq/blt/bltu into bne/bge/bgeu
    always_comb begin
        case (ex_ctrl.alu_control)
            alu_sub: begin
                cond = zero ^ ex_ctrl.funct3_0;
            end
            alu_slt, alu_sltu: begin
                cond = alu_result[0] ^ ex_ctrl.funct3_0;
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    assign pc_src_e = (ex_ctrl.branch & cond) | ex_ctrl.jump;

    // jalr target comes from the ALU, not from here
    assign pc_target_e = ex_data.pc + ex_data.imm_ext;

endmodule

`default_nettype wire

/* ex_mem_reg.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module ex_mem_reg
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush_e,
    input  ex_ctrl_t         ex_ctrl,
    input  ex_data_t         ex_data,
    input  logic [`XLEN-1:0] alu_result,
    input  logic [`XLEN-1:0] data_addr,
    input  logic [`XLEN-1:0] write_data,
    output mem_stage_t       mem_stage
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_stage <= '0;
        end else begin
            mem_stage.alu_result <= alu_result;
            mem_stage.data_addr  <= data_addr;
            mem_stage.write_data <= write_data;
            mem_stage.pc_plus4   <= ex_data.pc_plus4;
            mem_stage.imm_ext    <= ex_data.imm_ext;
            mem_stage.rd         <= ex_data.rd;
            // bubble: data still loads but nothing acts on it
            if (flush_e) begin
                mem_stage.reg_write  <= 1'b0;
                mem_stage.mem_write  <= 1'b0;
                mem_stage.mem_read   <= 1'b0;
                mem_stage.result_src <= res_alu;
            end else begin
                mem_stage.reg_write  <= ex_ctrl.reg_write;
                mem_stage.mem_write  <= ex_ctrl.mem_write;
                mem_stage.mem_read   <= ex_ctrl.mem_read;
                mem_stage.result_src <= ex_ctrl.result_src;
            end
        end
    end

endmodule

`default_nettype wire

/* exec_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module exec_top
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_e,
    input  ex_ctrl_t           ex_ctrl,
    input  ex_data_t           ex_data,
    input  logic [`XLEN-1:0]   result_w,
    input  logic [`REG_AW-1:0] rd_w,
    input  logic               reg_write_w,
    output logic               pc_src_e,
    output logic [`XLEN-1:0]   pc_target_e,
    output mem_stage_t         mem_stage,
    output logic [`XLEN-1:0]   data_addr,
    output logic [`XLEN-1:0]   data_to_memory,
    output logic               data_memory_we,
    output logic               data_memory_re
);

    fwd_ctrl_t        fwd;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] addr_e;
    logic             zero;

    forward_unit forward_unit_i (
        .ex_data     (ex_data),
        .mem_stage   (mem_stage),
        .rd_w        (rd_w),
        .reg_write_w (reg_write_w),
        .fwd         (fwd)
    );

    operand_mux operand_mux_i (
        .ex_ctrl   (ex_ctrl),
        .ex_data   (ex_data),
        .fwd       (fwd),
        .mem_stage (mem_stage),
        .result_w  (result_w),
        .src_a     (src_a),
        .src_b     (src_b),
        .fwd_b     (fwd_b)
    );

    alu alu_i (
        .a           (src_a),
        .b           (src_b),
        .imm_ext     (ex_data.imm_ext),
        .alu_control (ex_ctrl.alu_control),
        .result      (alu_result),
        .zero        (zero),
        .data_addr   (addr_e)
    );

    branch_unit branch_unit_i (
        .ex_ctrl     (ex_ctrl),
        .ex_data     (ex_data),
        .alu_result  (alu_result),
        .zero        (zero),
        .pc_src_e    (pc_src_e),
        .pc_target_e (pc_target_e)
    );

    // store data is the forwarded rs2, never the immediate
    ex_mem_reg ex_mem_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_e    (flush_e),
        .ex_ctrl    (ex_ctrl),
        .ex_data    (ex_data),
        .alu_result (alu_result),
        .data_addr  (addr_e),
        .write_data (fwd_b),
        .mem_stage  (mem_stage)
    );

    // data memory port runs from the registered bundle
    assign data_addr      = mem_stage.data_addr;
    assign data_to_memory = mem_stage.write_data;
    assign data_memory_we = mem_stage.mem_write;
    assign data_memory_re = mem_stage.mem_read;

endmodule

`default_nettype wire

/* tb_exec.sv */
`default_nettype none
`timescale 1ns/1ns

`include "exec_macros.svh"

module tb_exec
    import exec_pkg::*;
();

    localparam int NUM_INSTR      = 2000;
    localparam int RESET_CYCLES   = 16;
    // reset, one cycle per instruction, and some slack
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + 84;

    logic               clk;
    logic               rst_n;
    logic               flush_e;
    ex_ctrl_t           ex_ctrl;
    ex_data_t           ex_data;
    logic [`XLEN-1:0]   result_w;
    logic [`REG_AW-1:0] rd_w;
    logic               reg_write_w;
    logic               pc_src_e;
    logic [`XLEN-1:0]   pc_target_e;
    mem_stage_t         mem_stage;
    logic [`XLEN-1:0]   data_addr;
    logic [`XLEN-1:0]   data_to_memory;
    logic               data_memory_we;
    logic               data_memory_re;

    integer     seed = 76;
    int         cycle_count = 0;
    mem_stage_t exp_mem;
    logic       exp_bubble;

    exec_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_e        (flush_e),
        .ex_ctrl        (ex_ctrl),
        .ex_data        (ex_data),
        .result_w       (result_w),
        .rd_w           (rd_w),
        .reg_write_w    (reg_write_w),
        .pc_src_e       (pc_src_e),
        .pc_target_e    (pc_target_e),
        .mem_stage      (mem_stage),
        .data_addr      (data_addr),
        .data_to_memory (data_to_memory),
        .data_memory_we (data_memory_we),
        .data_memory_re (data_memory_re)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Finished with errors");
            $fatal(1, "timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_value(input string what, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    function automatic logic [`XLEN-1:0] alu_model(input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b,
                                                   input alu_op_t op);
        logic [`XLEN-1:0] r;
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = a - b;
            alu_and:    r = a & b;
            alu_or:     r = a | b;
            alu_xor:    r = a ^ b;
            alu_sltu:   r = (a < b) ? `XLEN'(1) : '0;
            alu_slt:    r = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
            alu_sll:    r = a << b[4:0];
            alu_srl:    r = a >> b[4:0];
            alu_sra:    r = $unsigned($signed(a) >>> b[4:0]);
            alu_pass_b: r = b;
            default:    r = '0;
        endcase
        return r;
    endfunction

    // memory stage beats writeback and neither x0 nor loads forward
    function automatic logic [`XLEN-1:0] forwarded_value(input logic [`REG_AW-1:0] rs,
                                                         input logic [`XLEN-1:0] reg_val);
        logic [`XLEN-1:0] v;
        v = reg_val;
        if (exp_mem.reg_write && exp_mem.rd != '0 && exp_mem.rd == rs &&
            exp_mem.result_src != res_mem) begin
            case (exp_mem.result_src)
                res_pc4: v = exp_mem.pc_plus4;
                res_imm: v = exp_mem.imm_ext;
                default: v = exp_mem.alu_result;
            endcase
        end else if (reg_write_w && rd_w != '0 && rd_w == rs) begin
            v = result_w;
        end
        return v;
    endfunction

    // small values half the time so that equal operands show up
    task automatic rand_operand(output logic [`XLEN-1:0] v);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        v = r1[0] ? `XLEN'(r2[1:0]) : r2;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        ex_ctrl.reg_write   = r[0];
        ex_ctrl.mem_write   = r[1];
        ex_ctrl.mem_read    = r[2];
        ex_ctrl.result_src  = result_src_t'(r[4:3]);
        ex_ctrl.alu_control = alu_op_t'(r[8:5] % 4'd11);
        ex_ctrl.alu_src     = r[9];
        ex_ctrl.pc_src_a    = r[10];
        ex_ctrl.branch      = r[11];
        ex_ctrl.jump        = (r[14:12] == 3'd0);
        ex_ctrl.funct3_0    = r[15];
        flush_e             = (r[18:16] == 3'd0);
        // registers 0 to 7 only
        ex_data.rs1         = `REG_AW'(r[21:19]);
        ex_data.rs2         = `REG_AW'(r[24:22]);
        ex_data.rd          = `REG_AW'(r[27:25]);
        rd_w                = `REG_AW'(r[30:28]);
        reg_write_w         = r[31];
        r = $random(seed);
        ex_data.pc       = {r[31:2], 2'b00};
        ex_data.pc_plus4 = ex_data.pc + 4;
        rand_operand(ex_data.imm_ext);
        rand_operand(ex_data.rd1);
        rand_operand(ex_data.rd2);
        rand_operand(result_w);
    endtask

    // same-cycle branch checks, then the bundle expected after the edge
    task automatic step_model();
        logic [`XLEN-1:0] fa;
        logic [`XLEN-1:0] fb;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic             cond;
        logic             take;
        fa  = forwarded_value(ex_data.rs1, ex_data.rd1);
        fb  = forwarded_value(ex_data.rs2, ex_data.rd2);
        a   = ex_ctrl.pc_src_a ? ex_data.pc : fa;
        b   = ex_ctrl.alu_src ? ex_data.imm_ext : fb;
        res = alu_model(a, b, ex_ctrl.alu_control);
        case (ex_ctrl.alu_control)
            alu_sub:           cond = (res == '0) ^ ex_ctrl.funct3_0;
            alu_slt, alu_sltu: cond = res[0] ^ ex_ctrl.funct3_0;
            default:           cond = 1'b0;
        endcase
        take = (ex_ctrl.branch && cond) || ex_ctrl.jump;
        check_value("pc_src_e", `XLEN'(pc_src_e), `XLEN'(take));
        check_value("pc_target_e", pc_target_e, ex_data.pc + ex_data.imm_ext);
        exp_bubble            = flush_e;
        exp_mem.reg_write     = flush_e ? 1'b0 : ex_ctrl.reg_write;
        exp_mem.mem_write     = flush_e ? 1'b0 : ex_ctrl.mem_write;
        exp_mem.mem_read      = flush_e ? 1'b0 : ex_ctrl.mem_read;
        exp_mem.result_src    = flush_e ? res_alu : ex_ctrl.result_src;
        exp_mem.alu_result    = res;
        exp_mem.data_addr     = a + ex_data.imm_ext;
        exp_mem.write_data    = fb;
        exp_mem.pc_plus4      = ex_data.pc_plus4;
        exp_mem.imm_ext       = ex_data.imm_ext;
        exp_mem.rd            = ex_data.rd;
    endtask

    task automatic compare_mem();
        check_value("reg_write_m", `XLEN'(mem_stage.reg_write), `XLEN'(exp_mem.reg_write));
        check_value("mem_write_m", `XLEN'(mem_stage.mem_write), `XLEN'(exp_mem.mem_write));
        check_value("mem_read_m", `XLEN'(mem_stage.mem_read), `XLEN'(exp_mem.mem_read));
        check_value("result_src_m", `XLEN'(mem_stage.result_src), `XLEN'(exp_mem.result_src));
        check_value("data_memory_we", `XLEN'(data_memory_we), `XLEN'(exp_mem.mem_write));
        check_value("data_memory_re", `XLEN'(data_memory_re), `XLEN'(exp_mem.mem_read));
        // bubble data is don't-care
        if (!exp_bubble) begin
            check_value("alu_result_m", mem_stage.alu_result, exp_mem.alu_result);
            check_value("data_addr", data_addr, exp_mem.data_addr);
            check_value("data_to_memory", data_to_memory, exp_mem.write_data);
            check_value("pc_plus4_m", mem_stage.pc_plus4, exp_mem.pc_plus4);
            check_value("imm_ext_m", mem_stage.imm_ext, exp_mem.imm_ext);
            check_value("rd_m", `XLEN'(mem_stage.rd), `XLEN'(exp_mem.rd));
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        flush_e     = 1'b0;
        // nonzero controls and data while reset is held
        ex_ctrl             = '1;
        ex_ctrl.alu_control = alu_add;
        ex_data             = '1;
        result_w    = '0;
        rd_w        = '0;
        reg_write_w = 1'b0;
        exp_mem     = '0;
        exp_bubble  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // still before the first rising edge after release
        compare_mem();
        for (int i = 0; i < NUM_INSTR; i++) begin
            drive_random();
            #1;
            step_model();
            @(negedge clk);
            compare_mem();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
exec_pkg.sv
alu.sv
forward_unit.sv
operand_mux.sv
branch_unit.sv
ex_mem_reg.sv
exec_top.sv
tb_exec.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec
FLAGS     ?= --binary --timing -j 0
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
